// File: common/frv_pkg.sv
/*
 * Shared package for the coprocessor subsystem
 * Wishbone request and response structs, instruction union,
 * opcodes, address map, register file sizes and write port struct
 */
package frv_pkg;

    localparam int unsigned XLEN        = 32;     // Register width
    localparam int unsigned GPR_COUNT   = 32;     // Architectural registers
    localparam int unsigned ADR_REG_BIT = 7;      // Set selects register read-back

    localparam logic [3:0] OP_ADD  = 4'd0;
    localparam logic [3:0] OP_SUB  = 4'd1;
    localparam logic [3:0] OP_CMOV = 4'd2;
    localparam logic [3:0] OP_MADD = 4'd3;        // 64-bit multiply-add, wide write
    localparam logic [3:0] OP_LI   = 4'd4;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [7:0]  adr;                         // Byte address
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic [3:0] op;                           // Bits 31:28
        logic [4:0] rd;                           // Bits 27:23
        logic [4:0] rs1;                          // Bits 22:18
        logic [4:0] rs2;                          // Bits 17:13
        logic [4:0] rs3;                          // Bits 12:8
        logic [7:0] rsvd;
    } r_fmt_t;

    typedef struct packed {
        logic [3:0]  op;
        logic [4:0]  rd;
        logic [22:0] imm;                         // Zero-extended on load
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_u;

    typedef struct packed {
        logic            wen;
        logic            wide;                    // Even/odd pair write
        logic [4:0]      addr;
        logic [XLEN-1:0] wdata;
        logic [XLEN-1:0] wdata_hi;                // Upper word of wide result
    } rd_wr_t;

endpackage

// File: exec/frv_gprs.sv
/*
 * General purpose register file
 * Even and odd banks, x0 hard-wired to zero, three combinational
 * read ports and a single write port with even/odd pair writes
 */
`timescale 1ns/100ps

module frv_gprs (
    input  logic                   g_clk,
    input  logic [4:0]             rs1_addr,
    input  logic [4:0]             rs2_addr,
    input  logic [4:0]             rs3_addr,
    output logic [frv_pkg::XLEN-1:0] rs1_data,
    output logic [frv_pkg::XLEN-1:0] rs2_data,
    output logic [frv_pkg::XLEN-1:0] rs3_data,
    input  frv_pkg::rd_wr_t        rd_wr
);

    import frv_pkg::*;

    logic [XLEN-1:0] gpr_even [GPR_COUNT/2];        // Entry 0 unused, x0 is zero
    logic [XLEN-1:0] gpr_odd  [GPR_COUNT/2];
    logic [XLEN-1:0] gpr_view [GPR_COUNT];          // Flat architectural view

    logic [3:0]      rd_top;
    logic            wen_even;
    logic            wen_odd;
    logic [XLEN-1:0] wdata_odd;

    assign rd_top    = rd_wr.addr[4:1];             // Pair index
    assign wen_even  = rd_wr.wen && !rd_wr.addr[0];
    assign wen_odd   = rd_wr.wen && (rd_wr.addr[0] || rd_wr.wide);
    assign wdata_odd = rd_wr.wide ? rd_wr.wdata_hi : rd_wr.wdata;

    // A wide write to an odd rd lands only the high word
    always_ff @(posedge g_clk) begin
        if (wen_even && rd_top != 4'd0) begin
            gpr_even[rd_top] <= rd_wr.wdata;
        end
        if (wen_odd) begin
            gpr_odd[rd_top] <= wdata_odd;
        end
    end

    always_comb begin
        gpr_view[0] = '0;                           // x0 hard-wired
        gpr_view[1] = gpr_odd[0];
        for (int i = 1; i < GPR_COUNT/2; i++) begin
            gpr_view[2*i]   = gpr_even[i];
            gpr_view[2*i+1] = gpr_odd[i];
        end
    end

    assign rs1_data = gpr_view[rs1_addr];
    assign rs2_data = gpr_view[rs2_addr];
    assign rs3_data = gpr_view[rs3_addr];

endmodule

// File: exec/frv_exec.sv
/*
 * Single-cycle execute unit
 * Decodes the instruction union, steers register read addresses,
 * computes ADD, SUB, CMOV, MADD and LI and drives the write port
 */
`timescale 1ns/100ps

module frv_exec (
    input  logic                                    issue,
    input  frv_pkg::instr_u                         instr,
    input  logic [$clog2(frv_pkg::GPR_COUNT)-1:0]   rb_addr,
    output logic [$clog2(frv_pkg::GPR_COUNT)-1:0]   rs1_addr,
    output logic [$clog2(frv_pkg::GPR_COUNT)-1:0]   rs2_addr,
    output logic [$clog2(frv_pkg::GPR_COUNT)-1:0]   rs3_addr,
    input  logic [frv_pkg::XLEN-1:0]                rs1_data,
    input  logic [frv_pkg::XLEN-1:0]                rs2_data,
    input  logic [frv_pkg::XLEN-1:0]                rs3_data,
    output logic [frv_pkg::XLEN-1:0]                rb_data,
    output frv_pkg::rd_wr_t                         rd_wr
);

    import frv_pkg::*;

    logic [3:0]        op;
    logic              known_op;
    logic [XLEN-1:0]   result;
    logic [2*XLEN-1:0] madd_res;

    assign op = instr.r_fmt.op;

    // rs1 port is shared with host read-back when nothing issues
    assign rs1_addr = issue ? instr.r_fmt.rs1 : rb_addr;
    assign rs2_addr = instr.r_fmt.rs2;
    assign rs3_addr = instr.r_fmt.rs3;
    assign rb_data  = rs1_data;

    // Unsigned 64-bit product plus zero-extended rs3
    assign madd_res = {{XLEN{1'b0}}, rs1_data} * {{XLEN{1'b0}}, rs2_data}
                    + {{XLEN{1'b0}}, rs3_data};

    always_comb begin
        known_op = 1'b1;
        result   = '0;
        case (op)
            OP_ADD:  result = rs1_data + rs2_data;
            OP_SUB:  result = rs1_data - rs2_data;
            OP_CMOV: result = (rs3_data != '0) ? rs1_data : rs2_data;
            OP_MADD: result = madd_res[XLEN-1:0];     // Low word
            OP_LI:   result = XLEN'(instr.i_fmt.imm); // Zero-extended immediate
            default: known_op = 1'b0;                 // No-op, still acknowledged
        endcase
    end

    assign rd_wr.wen      = issue && known_op;
    assign rd_wr.wide     = (op == OP_MADD);
    assign rd_wr.addr     = instr.r_fmt.rd;           // Same field in both formats
    assign rd_wr.wdata    = result;
    assign rd_wr.wdata_hi = madd_res[2*XLEN-1:XLEN];

endmodule

// File: hdl/frv_wb_front.sv
/*
 * Wishbone classic slave front end
 * Accepts one request at a time, decodes the address window,
 * issues instruction writes and returns register read-back data
 */
`timescale 1ns/100ps

module frv_wb_front (
    input  logic             g_clk,
    input  logic             rst_n,
    input  frv_pkg::wb_req_t wb_req,
    output frv_pkg::wb_rsp_t wb_rsp,
    output logic             issue,
    output frv_pkg::instr_u  instr,
    output logic [4:0]       rb_addr,
    input  logic [31:0]      rb_data
);

    import frv_pkg::*;

    logic        req_valid;
    logic        accept;
    logic        reg_win;
    logic        busy;
    logic        ack_q;
    logic [31:0] dat_q;

    assign req_valid = wb_req.cyc && wb_req.stb;
    assign accept    = req_valid && !busy;           // Idle state takes the request
    assign reg_win   = wb_req.adr[ADR_REG_BIT];

    // Instruction port writes execute in the accept cycle
    assign issue   = accept && wb_req.we && !reg_win;
    assign instr   = wb_req.dat;
    assign rb_addr = wb_req.adr[ADR_REG_BIT-1:2];    // Word index into register file

    // Busy holds from accept until the host drops stb
    always_ff @(posedge g_clk or negedge rst_n) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            ack_q <= 1'b0;
        end else begin
            ack_q <= accept;                         // Single-cycle ack
            busy  <= accept || (busy && wb_req.stb);
        end
    end

    // Read-back data captured at the accept edge
    always_ff @(posedge g_clk) begin
        if (accept) begin
            if (!wb_req.we && reg_win) begin
                dat_q <= rb_data;
            end else begin
                dat_q <= '0;                         // Instruction port reads and all writes
            end
        end
    end

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = dat_q;

endmodule

// File: hdl/frv_sub_top.sv
/*
 * Coprocessor subsystem top level
 * Wishbone front, execute unit and banked register file
 */
`timescale 1ns/100ps

module frv_sub_top (
    input  logic             g_clk,
    input  logic             rst_n,
    input  frv_pkg::wb_req_t wb_req,
    output frv_pkg::wb_rsp_t wb_rsp
);

    import frv_pkg::*;

    logic            issue;
    instr_u          instr;
    logic [4:0]      rb_addr;
    logic [XLEN-1:0] rb_data;
    logic [4:0]      rs1_addr;
    logic [4:0]      rs2_addr;
    logic [4:0]      rs3_addr;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] rs3_data;
    rd_wr_t          rd_wr;

    frv_wb_front front_i (
        .g_clk   (g_clk),
        .rst_n   (rst_n),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp),
        .issue   (issue),
        .instr   (instr),
        .rb_addr (rb_addr),
        .rb_data (rb_data)
    );

    frv_exec exec_i (
        .issue    (issue),
        .instr    (instr),
        .rb_addr  (rb_addr),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs3_addr (rs3_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rs3_data (rs3_data),
        .rb_data  (rb_data),
        .rd_wr    (rd_wr)
    );

    frv_gprs gprs_i (
        .g_clk    (g_clk),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs3_addr (rs3_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rs3_data (rs3_data),
        .rd_wr    (rd_wr)
    );

endmodule

// File: testbench/frv_sub_chk.sv
/*
 * Bus protocol and x0 assertions, bound to the subsystem top
 */
`timescale 1ns/100ps

module frv_sub_chk (
    input logic             g_clk,
    input logic             rst_n,
    input frv_pkg::wb_req_t wb_req,
    input frv_pkg::wb_rsp_t wb_rsp
);

    import frv_pkg::*;

    int assert_errors;                               // Failed assertion count

    initial assert_errors = 0;

    ack_single: assert property (@(posedge g_clk) disable iff (!rst_n)
        (wb_rsp.ack && wb_req.stb) |=> !wb_rsp.ack)
        else begin
            assert_errors++;
            $error("ack high in two cycles in a row while stb stayed high");
        end

    ack_after_req: assert property (@(posedge g_clk) disable iff (!rst_n)
        wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))
        else begin
            assert_errors++;
            $error("ack without a request in the previous cycle");
        end

    ack_in_reset: assert property (@(posedge g_clk)
        !rst_n |-> !wb_rsp.ack)
        else begin
            assert_errors++;
            $error("ack high during reset");
        end

    // Host read-back of x0 through the bus
    x0_zero: assert property (@(posedge g_clk) disable iff (!rst_n)
        (wb_rsp.ack && $past(!wb_req.we && wb_req.adr[ADR_REG_BIT]
                             && wb_req.adr[ADR_REG_BIT-1:2] == 5'd0))
        |-> (wb_rsp.dat == 32'd0))
        else begin
            assert_errors++;
            $error("register 0 read back nonzero");
        end

endmodule

bind frv_sub_top frv_sub_chk chk_i (
    .g_clk    (g_clk),
    .rst_n    (rst_n),
    .wb_req   (wb_req),
    .wb_rsp   (wb_rsp)
);

// File: testbench/tb_frv_sub.sv
/*
 * Testbench for the coprocessor subsystem
 * Clock, reset, Wishbone transfer tasks, stimulus table built with
 * a register model, watchdog and closing result line
 */
`timescale 1ns/100ps

module tb_frv_sub;

    import frv_pkg::*;

    localparam logic [1:0] K_INSTR = 2'd0;           // Write to instruction port
    localparam logic [1:0] K_WIN   = 2'd1;           // Write to register window
    localparam logic [1:0] K_IPRD  = 2'd2;           // Read of instruction port
    localparam logic [1:0] K_READ  = 2'd3;           // Read-back only

    typedef struct packed {
        logic [1:0]  kind;
        logic [31:0] word;                           // Instruction or write data
        logic [4:0]  reg_a;
        logic [31:0] exp_a;
        logic        chk_b;                          // Second register check
        logic [4:0]  reg_b;
        logic [31:0] exp_b;
    } entry_t;

    logic        g_clk;
    logic        rst_n;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;

    entry_t      table_q[$];
    logic [31:0] model_regs [32];
    logic        table_ready;
    logic [31:0] rdat;
    integer      seed;
    int          checks;
    int          reg_errors;
    int          port_errors;
    int          wd_ns;

    frv_sub_top dut_i (
        .g_clk  (g_clk),
        .rst_n  (rst_n),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    initial begin
        g_clk = 1'b0;
        forever #20 g_clk = ~g_clk;                  // 40 ns period
    end

    // Instruction word layouts
    function automatic logic [31:0] r_word(input logic [3:0] op, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2,
                                           input logic [4:0] rs3);
        return {op, rd, rs1, rs2, rs3, 8'h00};
    endfunction

    function automatic logic [31:0] i_word(input logic [3:0] op, input logic [4:0] rd,
                                           input logic [22:0] imm);
        return {op, rd, imm};
    endfunction

    task automatic model_write(input logic [4:0] r, input logic [31:0] v);
        if (r != 5'd0) begin
            model_regs[r] = v;                       // x0 stays zero
        end
    endtask

    task automatic push(input logic [1:0] kind, input logic [31:0] word,
                        input logic [4:0] ra, input logic chk_b, input logic [4:0] rb);
        entry_t e;
        e.kind  = kind;
        e.word  = word;
        e.reg_a = ra;
        e.exp_a = model_regs[ra];
        e.chk_b = chk_b;
        e.reg_b = rb;
        e.exp_b = model_regs[rb];
        table_q.push_back(e);
    endtask

    task automatic add_li(input logic [4:0] rd, input logic [22:0] imm);
        model_write(rd, {9'd0, imm});
        push(K_INSTR, i_word(OP_LI, rd, imm), rd, 1'b0, 5'd0);
    endtask

    task automatic add_op(input logic [3:0] op, input logic [4:0] rd, input logic [4:0] rs1,
                          input logic [4:0] rs2, input logic [4:0] rs3);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [63:0] prod;
        a    = model_regs[rs1];
        b    = model_regs[rs2];
        c    = model_regs[rs3];
        prod = {32'd0, a} * {32'd0, b} + {32'd0, c};
        case (op)
            OP_ADD:  model_write(rd, a + b);
            OP_SUB:  model_write(rd, a - b);
            OP_CMOV: model_write(rd, (c != 0) ? a : b);
            OP_MADD: begin
                if (!rd[0]) begin
                    model_write(rd, prod[31:0]);
                    model_write(rd ^ 5'd1, prod[63:32]);  // High word to odd partner
                end else begin
                    model_write(rd, prod[63:32]);
                end
            end
            default: ;                               // Unknown opcode changes nothing
        endcase
        push(K_INSTR, r_word(op, rd, rs1, rs2, rs3), rd, op == OP_MADD, rd ^ 5'd1);
    endtask

    // One classic cycle, request held until ack is seen
    task automatic wb_xfer(input logic we, input logic [7:0] adr, input logic [31:0] dat,
                           input logic hold, output logic [31:0] rd_data);
        @(posedge g_clk);
        #2;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = dat;
        @(posedge g_clk);
        #1;
        while (!wb_rsp.ack) begin
            @(posedge g_clk);
            #1;
        end
        rd_data = wb_rsp.dat;
        if (hold) begin
            @(posedge g_clk);                        // Extra cycle with stb still high
            #1;
        end
        #1;
        wb_req = '0;
    endtask

    task automatic check_reg(input logic [4:0] r, input logic [31:0] exp);
        logic [31:0] got;
        wb_xfer(1'b0, {1'b1, r, 2'b00}, 32'd0, 1'b0, got);
        checks++;
        if (got !== exp) begin
            reg_errors++;
            $display("Fail %0t: x%0d read %h, expected %h", $time, r, got, exp);
        end
    endtask

    initial begin
        wd_ns = 0;
        wait (table_ready === 1'b1);
        wd_ns = (table_q.size() * 8 + 5 + 4) * 40;   // Entries plus reset and slack
        #(wd_ns);
        $display("Timeout: the DUT stopped answering and the run hung");
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        wb_req      = '0;
        rst_n       = 1'b0;
        table_ready = 1'b0;
        seed        = 94;
        checks      = 0;
        reg_errors  = 0;
        port_errors = 0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = 32'd0;
        end

        for (int r = 1; r < 32; r++) begin
            add_li(5'(r), 23'($random(seed)));       // Operands for later entries
        end
        add_op(OP_ADD, 5'd5, 5'd1, 5'd2, 5'd0);
        add_op(OP_SUB, 5'd6, 5'd3, 5'd4, 5'd0);
        add_op(OP_SUB, 5'd7, 5'd4, 5'd3, 5'd0);
        add_op(OP_ADD, 5'd8, 5'd9, 5'd0, 5'd0);
        add_op(OP_CMOV, 5'd11, 5'd12, 5'd13, 5'd0);  // rs3 is x0
        add_op(OP_CMOV, 5'd14, 5'd15, 5'd16, 5'd17);
        add_li(5'd18, 23'd0);
        add_op(OP_CMOV, 5'd19, 5'd20, 5'd21, 5'd18);
        add_op(OP_MADD, 5'd22, 5'd23, 5'd24, 5'd25);
        add_op(OP_MADD, 5'd27, 5'd28, 5'd29, 5'd30); // Odd rd, x26 must hold
        add_li(5'd0, 23'($random(seed)));
        add_op(OP_MADD, 5'd0, 5'd2, 5'd3, 5'd4);
        push(K_IPRD, 32'd0, 5'd0, 1'b0, 5'd0);
        // LI word to x12 with a different immediate, must not execute
        push(K_WIN, i_word(OP_LI, 5'd12, ~model_regs[12][22:0]), 5'd12, 1'b0, 5'd0);
        add_op(4'hF, 5'd13, 5'd1, 5'd2, 5'd3);
        add_op(4'h9, 5'd20, 5'd4, 5'd5, 5'd6);
        push(K_READ, 32'd0, 5'd9, 1'b1, 5'd10);
        push(K_READ, 32'd0, 5'd12, 1'b1, 5'd13);
        push(K_READ, 32'd0, 5'd20, 1'b1, 5'd21);
        table_ready = 1'b1;

        repeat (5) @(posedge g_clk);
        #2;
        rst_n = 1'b1;

        foreach (table_q[i]) begin
            case (table_q[i].kind)
                K_INSTR: wb_xfer(1'b1, 8'h00, table_q[i].word, 1'b0, rdat);
                K_WIN:   wb_xfer(1'b1, {1'b1, table_q[i].reg_a, 2'b00}, table_q[i].word,
                                 1'b1, rdat);
                K_IPRD:  wb_xfer(1'b0, 8'h04, 32'd0, 1'b1, rdat);
                default: ;
            endcase
            if (table_q[i].kind == K_IPRD) begin
                checks++;
                if (rdat !== 32'd0) begin
                    port_errors++;
                    $display("Fail %0t: instruction port read %h, expected 0", $time, rdat);
                end
            end else begin
                check_reg(table_q[i].reg_a, table_q[i].exp_a);
            end
            if (table_q[i].chk_b) begin
                check_reg(table_q[i].reg_b, table_q[i].exp_b);
            end
        end

        $display("Checks: %0d, register errors: %0d, port errors: %0d, assertion errors: %0d",
                 checks, reg_errors, port_errors, dut_i.chk_i.assert_errors);
        if (reg_errors == 0 && port_errors == 0 && dut_i.chk_i.assert_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
common/frv_pkg.sv
exec/frv_gprs.sv
exec/frv_exec.sv
hdl/frv_wb_front.sv
hdl/frv_sub_top.sv
testbench/frv_sub_chk.sv
testbench/tb_frv_sub.sv

// File: Bender.yml
package:
  name: frv_sub

sources:
  # Design sources in compile order
  - files:
      - common/frv_pkg.sv
      - exec/frv_gprs.sv
      - exec/frv_exec.sv
      - hdl/frv_wb_front.sv
      - hdl/frv_sub_top.sv

  # Testbench and bound assertions
  - target: test
    files:
      - testbench/frv_sub_chk.sv
      - testbench/tb_frv_sub.sv
